// ==== mci_top.f ====
+incdir+verilog
verilog/mci_pkg.sv
verilog/mci_req_decode.sv
verilog/mci_mcu_sram_ctrl.sv
verilog/mci_wdt.sv
verilog/mci_regs.sv
verilog/mci_top.sv
verification/mci_props.sv
verification/mci_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MCI testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mci_tb -f mci_top.f \
    > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vmci_tb > sim.log 2>&1
cat sim.log

grep -qx '\*\*\* PASSED \*\*\*' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verification/mci_props.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCI protocol checks: response timing, SRAM chip select gating, NMI order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mci_cfg.svh"

module mci_props
    import mci_pkg::*;
(
    input logic                   clk,
    input logic                   rst_n,
    input mci_req_t               req,
    input mci_rsp_t               rsp,
    input logic [`MCI_USER_W-1:0] strap_mcu_user,
    input logic [`MCI_USER_W-1:0] strap_clp_user,
    input logic                   exec_region_lock,
    input logic [`MCI_DATA_W-1:0] exec_region_size,
    input mci_sram_req_t          sram_req,
    input logic                   t1_timeout,
    input logic                   nmi_intr
);

    logic [`MCI_ADDR_W-3:0] word_idx;
    logic                   from_mcu;
    logic                   from_clp;
    logic                   exec_word;
    logic                   sram_allowed;

    // Access rules seen from the fabric port
    assign word_idx  = req.addr[`MCI_ADDR_W-2:2];
    assign from_mcu  = (req.user == strap_mcu_user);
    assign from_clp  = (req.user == strap_clp_user) && !from_mcu;
    assign exec_word = `MCI_DATA_W'(word_idx) < exec_region_size;

    // Locked region belongs to MCU, unlocked to CLP
    assign sram_allowed = req.dv && req.addr[`MCI_SRAM_SEL_BIT]
                          && (word_idx < `MCI_SRAM_DEPTH)
                          && (!exec_word || (exec_region_lock ? from_mcu : from_clp));

    // Every request answered in the next cycle, never spontaneously
    rsp_follows_dv: assert property (@(posedge clk) disable iff (!rst_n)
        req.dv |=> rsp.valid)
        else $error("no response one cycle after a request");
    rsp_needs_dv: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.valid |-> $past(req.dv))
        else $error("response without a request in the previous cycle");

    // cs never on an access the rules reject
    cs_only_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        sram_req.cs |-> sram_allowed)
        else $error("SRAM chip select asserted for a rejected access");

    // Stage 2 only runs behind a pending stage 1 expiry
    nmi_after_t1: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(nmi_intr) |-> $past(t1_timeout))
        else $error("NMI raised without a pending first stage timeout");

endmodule

bind mci_top mci_props u_mci_props (
    .clk              (clk),
    .rst_n            (rst_n),
    .req              (req),
    .rsp              (rsp),
    .strap_mcu_user   (strap_mcu_user),
    .strap_clp_user   (strap_clp_user),
    .exec_region_lock (mcu_sram_exec_region_lock),
    .exec_region_size (exec_region_size),
    .sram_req         (sram_req),
    .t1_timeout       (t1_timeout),
    .nmi_intr         (nmi_intr)
);

// ==== verification/mci_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCI testbench: SRAM model, vector driven CSR/SRAM accesses and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mci_cfg.svh"

module mci_tb
    import mci_pkg::*;
();

    localparam string          VEC_FILE = "verification/mci_vectors.txt";
    // User field values per requester class
    localparam logic [7:0]     MCU_USER = 8'h11;
    localparam logic [7:0]     CLP_USER = 8'h22;
    localparam logic [7:0]     SOC_USER = 8'h5c;

    logic                   clk;
    logic                   rst_n;
    mci_req_t               req;
    mci_rsp_t               rsp;
    logic                   lock;
    mci_sram_req_t          sram_req;
    logic [`MCI_DATA_W:0]   sram_rdata;
    logic                   error_fatal;
    logic                   nmi_intr;

    // External memory, data plus parity bit
    logic [`MCI_DATA_W:0]   sram_mem [`MCI_SRAM_DEPTH];

    // Parsed vectors, one entry per operation
    logic [7:0]             vec_op [$];
    int                     vec_src [$];
    logic [31:0]            vec_a [$];
    logic [31:0]            vec_b [$];
    int                     vec_c [$];

    int                     errors = 0;
    int                     checks = 0;
    int                     cycle_cnt = 0;
    int                     cycle_limit = 100000;

    mci_top dut0 (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .req                       (req),
        .rsp                       (rsp),
        .strap_mcu_user            (MCU_USER),
        .strap_clp_user            (CLP_USER),
        .mcu_sram_exec_region_lock (lock),
        .sram_req                  (sram_req),
        .sram_rdata                (sram_rdata),
        .error_fatal               (error_fatal),
        .nmi_intr                  (nmi_intr)
    );

    always #5 clk = ~clk;

    // One cycle read latency
    always @(posedge clk) begin
        if (sram_req.cs) begin
            if (sram_req.we) begin
                sram_mem[sram_req.addr] <= sram_req.wdata;
            end else begin
                sram_rdata <= sram_mem[sram_req.addr];
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, DUT stopped responding", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Pattern from the whole word index, stored with good parity
    function automatic logic [32:0] fill_word(input int idx);
        logic [31:0] d;
        d = {8'hc0, idx[7:0], ~idx[7:0], idx[7:0]};
        return {^d, d};
    endfunction

    function automatic logic [7:0] user_of(input int src);
        case (src)
            0:       return MCU_USER;
            1:       return CLP_USER;
            default: return SOC_USER;
        endcase
    endfunction

    task automatic load_vectors();
        int          fd;
        int          rc;
        int          c;
        int          src;
        int          num;
        logic [7:0]  tok;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open vector file %s", VEC_FILE);
            errors++;
            return;
        end
        cycle_limit = 100;
        rc = $fscanf(fd, "%s", tok);
        while (rc == 1) begin
            src = 0;
            num = 0;
            a   = '0;
            b   = '0;
            case (tok)
                // Comment, skip to end of line
                "#": begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                "W", "R": begin
                    rc = $fscanf(fd, "%d %h %h %d", src, a, b, num);
                    cycle_limit += 4;
                end
                "L":     rc = $fscanf(fd, "%d", num);
                "F":     rc = $fscanf(fd, "%h %d", a, b);
                "N": begin
                    rc = $fscanf(fd, "%d", num);
                    cycle_limit += num;
                end
                "P":     rc = $fscanf(fd, "%h %h", a, b);
                default: begin
                    $display("Unknown opcode %s in vector file", tok);
                    errors++;
                end
            endcase
            if (tok != "#") begin
                vec_op.push_back(tok);
                vec_src.push_back(src);
                vec_a.push_back(a);
                vec_b.push_back(b);
                vec_c.push_back(num);
            end
            rc = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
    endtask

    // Single beat access, dv held one cycle, response checked on arrival
    task automatic issue_access(input bit wr, input int src, input logic [31:0] addr,
                                input logic [31:0] data, input int exp_err);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk);
        #1;
        req.dv    = 1'b1;
        req.write = wr;
        req.addr  = addr[`MCI_ADDR_W-1:0];
        req.wdata = wr ? data : '0;
        req.user  = user_of(src);
        @(posedge clk);
        #1;
        req.dv = 1'b0;
        while (!rsp.valid && wait_cnt < 4) begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        checks++;
        assert (rsp.valid) else begin
            errors++;
            $display("No response to access at address %h", addr);
        end
        if (rsp.valid) begin
            assert (rsp.error == exp_err[0]) else begin
                errors++;
                $display("ERR %0t rsp.error got %0b expected %0b (addr %h)",
                         $time, rsp.error, exp_err[0], addr);
            end
            // Only reads carry data worth comparing
            if (!wr) begin
                assert (rsp.rdata == data) else begin
                    errors++;
                    $display("ERR %0t rsp.rdata got %h expected %h (addr %h)",
                             $time, rsp.rdata, data, addr);
                end
            end
        end
    endtask

    task automatic apply_vector(input int i);
        int idx;
        int bit_pos;
        idx     = int'(vec_a[i][7:0]);
        bit_pos = int'(vec_b[i][5:0]);
        case (vec_op[i])
            "W": issue_access(1'b1, vec_src[i], vec_a[i], vec_b[i], vec_c[i]);
            "R": issue_access(1'b0, vec_src[i], vec_a[i], vec_b[i], vec_c[i]);
            "L": begin
                @(posedge clk);
                #1;
                lock = vec_c[i][0];
            end
            // Corrupt a stored word behind the DUT
            "F": begin
                @(posedge clk);
                #1;
                sram_mem[idx] = sram_mem[idx] ^ (33'd1 << bit_pos);
            end
            "N": repeat (vec_c[i]) @(posedge clk);
            "P": begin
                @(posedge clk);
                #1;
                checks++;
                assert (error_fatal == vec_a[i][0]) else begin
                    errors++;
                    $display("ERR %0t error_fatal got %0b expected %0b",
                             $time, error_fatal, vec_a[i][0]);
                end
                assert (nmi_intr == vec_b[i][0]) else begin
                    errors++;
                    $display("ERR %0t nmi_intr got %0b expected %0b",
                             $time, nmi_intr, vec_b[i][0]);
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        req        = '0;
        lock       = 1'b0;
        sram_rdata = '0;
        for (int i = 0; i < `MCI_SRAM_DEPTH; i++) begin
            sram_mem[i] = fill_word(i);
        end
        load_vectors();

        // Reset for 3 cycles
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (vec_op[i]) begin
            apply_vector(i);
        end
        repeat (2) @(posedge clk);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verification/mci_vectors.txt ====
# W|R src(0 MCU,1 CLP,2 SoC) addr(hex) data(hex, expected on R) err ; L lock ; N cycles
# F word(hex) bit ; P error_fatal nmi_intr
# reset values and unmapped offsets
R 0 0008 00000400 0
R 2 000C 00000400 0
R 1 0014 00000000 0
R 0 0010 00000000 0
R 0 0018 00000000 0
R 0 001C 00000000 1
W 1 0020 0000ffff 1
# write privilege
W 0 0008 00000055 0
R 2 0008 00000055 0
W 1 0008 00000077 0
R 0 0008 00000077 0
W 2 0008 12345678 1
R 1 0008 00000077 0
W 2 0014 00000003 1
R 0 0014 00000000 0
# SRAM data, range and parity
W 2 8040 a5a5a5a5 0
R 0 8040 a5a5a5a5 0
R 1 8040 a5a5a5a5 0
W 0 83FC 0badf00d 0
R 2 83FC 0badf00d 0
R 2 8008 c002fd02 0
R 0 8400 00000000 1
W 1 8400 11111111 1
F 10 3
R 0 8040 a5a5a5ad 1
P 1 0
R 0 0018 00000001 0
W 0 0018 00000001 0
R 0 0018 00000000 0
P 0 0
# execution region lock
W 0 0014 00000010 0
L 0
W 1 8000 01020304 0
R 1 8000 01020304 0
R 0 8000 00000000 1
W 0 8004 deadbeef 1
L 1
R 1 8000 00000000 1
R 0 8000 01020304 0
W 0 8004 deadbeef 0
R 0 8004 deadbeef 0
W 1 8004 00000000 1
R 2 803C 00000000 1
R 2 8044 c011ee11 0
W 1 8048 00c0ffee 0
R 0 8048 00c0ffee 0
# watchdog first stage
W 0 0008 00000014 0
W 0 0000 00000001 0
N 30
R 0 0010 00000001 0
W 0 0010 00000001 0
R 0 0010 00000000 0
W 1 0004 00000001 0
N 10
R 0 0010 00000000 0
# watchdog second stage
W 0 000C 0000000A 0
N 40
P 1 1
R 0 0010 00000003 0
W 0 0000 00000000 0
W 0 0010 00000003 0
W 0 0018 00000003 0
R 0 0010 00000000 0
R 0 0018 00000000 0
P 0 0

// ==== verilog/mci_cfg.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCI configuration: bus widths, SRAM geometry, CSR map and reset values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MCI_CFG_SVH
`define MCI_CFG_SVH

// Fabric request widths
`define MCI_ADDR_W          16
`define MCI_DATA_W          32
`define MCI_USER_W          8

// MCU SRAM geometry, word index taken from addr[9:2]
`define MCI_SRAM_DEPTH      256
`define MCI_SRAM_AW         8
// Addr bit 15 set selects SRAM, clear selects CSRs
`define MCI_SRAM_SEL_BIT    15

// Reset values
`define MCI_WDT_DEF_PERIOD  32'h0000_0400
`define MCI_EXEC_SIZE_DEF   32'h0000_0000

// CSR byte offsets, sized to the address width
`define MCI_REG_T1_EN       16'h0000
`define MCI_REG_T1_CTRL     16'h0004
`define MCI_REG_T1_PERIOD   16'h0008
`define MCI_REG_T2_PERIOD   16'h000C
`define MCI_REG_WDT_STATUS  16'h0010
`define MCI_REG_EXEC_SIZE   16'h0014
`define MCI_REG_ERR_STATUS  16'h0018

`endif

// ==== verilog/mci_mcu_sram_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCU SRAM controller: exec region access control, parity, SRAM port drive
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mci_cfg.svh"

module mci_mcu_sram_ctrl
    import mci_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Request from decoder
    input  mci_req_t               sram_req_in,
    input  mci_src_e               src,

    // Exec region controls
    input  logic [`MCI_DATA_W-1:0] exec_region_size,
    input  logic                   exec_region_lock,

    // SRAM read data, parity in top bit
    input  logic [`MCI_DATA_W:0]   sram_rdata,

    output mci_rsp_t               sram_rsp,
    output mci_sram_req_t          sram_req,
    output logic                   sram_parity_error
);

    // Word index covers addr[14:2] so oversized indexes are visible
    localparam int IDX_W = `MCI_ADDR_W - 3;

    logic [IDX_W-1:0] word_idx;
    logic             in_range;
    logic             in_exec;
    logic             exec_ok;
    logic             access_ok;
    logic             rsp_valid_q;
    logic             rsp_rej_q;
    logic             rd_pend_q;
    logic             rd_par_bad;

    assign word_idx = sram_req_in.addr[`MCI_ADDR_W-2:2];
    assign in_range = word_idx < IDX_W'(`MCI_SRAM_DEPTH);
    assign in_exec  = `MCI_DATA_W'(word_idx) < exec_region_size;

    // Lock hands the exec region from CLP to MCU
    always_comb begin
        if (exec_region_lock) begin
            exec_ok = (src == SRC_MCU);
        end else begin
            exec_ok = (src == SRC_CLP);
        end
    end

    // Outside exec region anyone may access
    assign access_ok = in_range & (~in_exec | exec_ok);

    // SRAM port, cs only for permitted accesses
    always_comb begin
        sram_req.cs    = sram_req_in.dv & access_ok;
        sram_req.we    = sram_req_in.write;
        sram_req.addr  = word_idx[`MCI_SRAM_AW-1:0];
        // Even parity over the data word
        sram_req.wdata = {^sram_req_in.wdata, sram_req_in.wdata};
    end

    // Response bookkeeping for the cycle after dv
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
            rsp_rej_q   <= 1'b0;
            rd_pend_q   <= 1'b0;
        end else begin
            rsp_valid_q <= sram_req_in.dv;
            rsp_rej_q   <= sram_req_in.dv & ~access_ok;
            rd_pend_q   <= sram_req_in.dv & access_ok & ~sram_req_in.write;
        end
    end

    // Odd total ones means a corrupted word
    assign rd_par_bad = rd_pend_q & (^sram_rdata);

    always_comb begin
        sram_rsp.valid = rsp_valid_q;
        sram_rsp.error = rsp_rej_q | rd_par_bad;
        // Rejected reads and writes return 0
        sram_rsp.rdata = rd_pend_q ? sram_rdata[`MCI_DATA_W-1:0] : '0;
    end

    assign sram_parity_error = rd_par_bad;

endmodule

// ==== verilog/mci_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCI shared types: fabric request/response, SRAM port, requester class
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mci_cfg.svh"

package mci_pkg;

    // Requester class from user field vs straps
    typedef enum logic [1:0] {
        SRC_MCU = 2'd0,
        SRC_CLP = 2'd1,
        SRC_SOC = 2'd2
    } mci_src_e;

    // Single-beat fabric request
    typedef struct packed {
        logic                   dv;
        logic                   write;
        logic [`MCI_ADDR_W-1:0] addr;
        logic [`MCI_DATA_W-1:0] wdata;
        logic [`MCI_USER_W-1:0] user;
    } mci_req_t;

    // Response, valid for one cycle
    typedef struct packed {
        logic                   valid;
        logic                   error;
        logic [`MCI_DATA_W-1:0] rdata;
    } mci_rsp_t;

    // External SRAM port
    // wdata[32] carries even parity
    typedef struct packed {
        logic                   cs;
        logic                   we;
        logic [`MCI_SRAM_AW-1:0] addr;
        logic [`MCI_DATA_W:0]   wdata;
    } mci_sram_req_t;

endpackage

// ==== verilog/mci_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCI CSR bank: watchdog controls, exec region size, error status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mci_cfg.svh"

module mci_regs
    import mci_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Request from decoder
    input  mci_req_t               reg_req,
    input  mci_src_e               src,

    // Watchdog status
    input  logic                   t1_timeout_p,
    input  logic                   t2_timeout_p,
    input  logic                   t1_timeout,
    input  logic                   t2_timeout,

    // SRAM error event
    input  logic                   sram_parity_error,

    output mci_rsp_t               reg_rsp,

    // Watchdog controls
    output logic                   timer1_en,
    output logic                   restart,
    output logic [`MCI_DATA_W-1:0] timer1_period,
    output logic [`MCI_DATA_W-1:0] timer2_period,
    output logic                   t1_serviced,
    output logic                   t2_serviced,

    output logic [`MCI_DATA_W-1:0] exec_region_size,
    output logic                   error_fatal
);

    logic                   wr_en;
    logic                   soc_wr;
    logic                   mapped;
    logic [`MCI_DATA_W-1:0] rd_data;
    logic [1:0]             err_status;
    logic [1:0]             err_set;
    logic                   rsp_valid_q;
    logic                   rsp_err_q;
    logic [`MCI_DATA_W-1:0] rsp_rdata_q;

    // SoC may read but never write
    assign soc_wr = reg_req.dv & reg_req.write & (src == SRC_SOC);
    assign wr_en  = reg_req.dv & reg_req.write & (src != SRC_SOC);

    // Bit 0 parity, bit 1 stage 2 expiry
    assign err_set = {t2_timeout_p, sram_parity_error};

    // Read mux and offset decode
    always_comb begin
        mapped = 1'b1;
        case (reg_req.addr)
            `MCI_REG_T1_EN:      rd_data = `MCI_DATA_W'(timer1_en);
            // Restart bit self-clears, reads 0
            `MCI_REG_T1_CTRL:    rd_data = '0;
            `MCI_REG_T1_PERIOD:  rd_data = timer1_period;
            `MCI_REG_T2_PERIOD:  rd_data = timer2_period;
            `MCI_REG_WDT_STATUS: rd_data = `MCI_DATA_W'({t2_timeout, t1_timeout});
            `MCI_REG_EXEC_SIZE:  rd_data = exec_region_size;
            `MCI_REG_ERR_STATUS: rd_data = `MCI_DATA_W'(err_status);
            default: begin
                rd_data = '0;
                mapped  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timer1_en        <= 1'b0;
            restart          <= 1'b0;
            timer1_period    <= `MCI_WDT_DEF_PERIOD;
            timer2_period    <= `MCI_WDT_DEF_PERIOD;
            t1_serviced      <= 1'b0;
            t2_serviced      <= 1'b0;
            exec_region_size <= `MCI_EXEC_SIZE_DEF;
            err_status       <= 2'b00;
            rsp_valid_q      <= 1'b0;
            rsp_err_q        <= 1'b0;
        end else begin
            // Pulses last one cycle
            restart     <= 1'b0;
            t1_serviced <= 1'b0;
            t2_serviced <= 1'b0;
            // Sticky error capture
            err_status  <= err_status | err_set;

            if (wr_en) begin
                case (reg_req.addr)
                    `MCI_REG_T1_EN:      timer1_en <= reg_req.wdata[0];
                    `MCI_REG_T1_CTRL:    restart <= reg_req.wdata[0];
                    `MCI_REG_T1_PERIOD:  timer1_period <= reg_req.wdata;
                    `MCI_REG_T2_PERIOD:  timer2_period <= reg_req.wdata;
                    `MCI_REG_WDT_STATUS: begin
                        // Service only an expiry that is pending or just signalled
                        t1_serviced <= reg_req.wdata[0] & (t1_timeout | t1_timeout_p);
                        t2_serviced <= reg_req.wdata[1] & t2_timeout;
                    end
                    `MCI_REG_EXEC_SIZE:  exec_region_size <= reg_req.wdata;
                    // W1C, a new event in the same cycle stays set
                    `MCI_REG_ERR_STATUS: begin
                        err_status <= (err_status & ~reg_req.wdata[1:0]) | err_set;
                    end
                    default: ;
                endcase
            end

            rsp_valid_q <= reg_req.dv;
            rsp_err_q   <= reg_req.dv & (~mapped | soc_wr);
        end
    end

    // Read data capture
    always_ff @(posedge clk) begin
        if (reg_req.dv && !reg_req.write && mapped) begin
            rsp_rdata_q <= rd_data;
        end else begin
            rsp_rdata_q <= '0;
        end
    end

    always_comb begin
        reg_rsp.valid = rsp_valid_q;
        reg_rsp.error = rsp_err_q;
        reg_rsp.rdata = rsp_rdata_q;
    end

    // Any latched error is fatal
    assign error_fatal = |err_status;

endmodule

// ==== verilog/mci_req_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCI request decoder: classifies the requester and steers to CSR or SRAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mci_cfg.svh"

module mci_req_decode
    import mci_pkg::*;
(
    // Fabric side
    input  mci_req_t               req,

    // Privileged users
    input  logic [`MCI_USER_W-1:0] strap_mcu_user,
    input  logic [`MCI_USER_W-1:0] strap_clp_user,

    // Targets
    output mci_req_t               reg_req,
    output mci_req_t               sram_req_in,
    output mci_src_e               src
);

    logic sram_sel;

    // Region select on the top address bit
    assign sram_sel = req.addr[`MCI_SRAM_SEL_BIT];

    // MCU takes priority when both straps match
    always_comb begin
        if (req.user == strap_mcu_user) begin
            src = SRC_MCU;
        end else if (req.user == strap_clp_user) begin
            src = SRC_CLP;
        end else begin
            src = SRC_SOC;
        end
    end

    // Payload goes to both, dv to only one
    always_comb begin
        reg_req        = req;
        reg_req.dv     = req.dv & ~sram_sel;
        sram_req_in    = req;
        sram_req_in.dv = req.dv & sram_sel;
    end

endmodule

// ==== verilog/mci_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCI top: request decode, MCU SRAM, watchdog and CSR bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mci_cfg.svh"

module mci_top
    import mci_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // Fabric port
    input  mci_req_t               req,
    output mci_rsp_t               rsp,

    // Straps
    input  logic [`MCI_USER_W-1:0] strap_mcu_user,
    input  logic [`MCI_USER_W-1:0] strap_clp_user,
    input  logic                   mcu_sram_exec_region_lock,

    // External SRAM
    output mci_sram_req_t          sram_req,
    input  logic [`MCI_DATA_W:0]   sram_rdata,

    output logic                   error_fatal,
    output logic                   nmi_intr
);

    // Decoder outputs
    mci_req_t               reg_req;
    mci_req_t               sram_req_in;
    mci_src_e               src;
    mci_rsp_t               reg_rsp;
    mci_rsp_t               sram_rsp;

    logic [`MCI_DATA_W-1:0] exec_region_size;
    logic                   sram_parity_error;

    // WDT signals
    logic                   timer1_en;
    logic                   restart;
    logic [`MCI_DATA_W-1:0] timer1_period;
    logic [`MCI_DATA_W-1:0] timer2_period;
    logic                   t1_serviced;
    logic                   t2_serviced;
    logic                   t1_timeout_p;
    logic                   t2_timeout_p;
    logic                   t1_timeout;
    logic                   t2_timeout;

    mci_req_decode i_mci_req_decode (
        .req,
        .strap_mcu_user,
        .strap_clp_user,
        .reg_req,
        .sram_req_in,
        .src
    );

    mci_mcu_sram_ctrl i_mci_mcu_sram_ctrl (
        .clk,
        .rst_n,
        .sram_req_in,
        .src,
        .exec_region_size,
        .exec_region_lock (mcu_sram_exec_region_lock),
        .sram_rdata,
        .sram_rsp,
        .sram_req,
        .sram_parity_error
    );

    // Stage 2 expiry drives the NMI
    mci_wdt i_mci_wdt (
        .clk,
        .rst_n,
        .timer1_en,
        .restart,
        .timer1_period,
        .timer2_period,
        .t1_serviced,
        .t2_serviced,
        .t1_timeout_p,
        .t2_timeout_p,
        .t1_timeout,
        .t2_timeout,
        .fatal_timeout (nmi_intr)
    );

    mci_regs i_mci_regs (
        .clk,
        .rst_n,
        .reg_req,
        .src,
        .t1_timeout_p,
        .t2_timeout_p,
        .t1_timeout,
        .t2_timeout,
        .sram_parity_error,
        .reg_rsp,
        .timer1_en,
        .restart,
        .timer1_period,
        .timer2_period,
        .t1_serviced,
        .t2_serviced,
        .exec_region_size,
        .error_fatal
    );

    // Only one target responds per request
    assign rsp = mci_rsp_t'(reg_rsp | sram_rsp);

endmodule

// ==== verilog/mci_wdt.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MCI watchdog: cascaded two-stage timer, second expiry raises NMI
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mci_cfg.svh"

module mci_wdt (
    input  logic                   clk,
    input  logic                   rst_n,

    // Controls from CSR bank
    input  logic                   timer1_en,
    input  logic                   restart,
    input  logic [`MCI_DATA_W-1:0] timer1_period,
    input  logic [`MCI_DATA_W-1:0] timer2_period,
    input  logic                   t1_serviced,
    input  logic                   t2_serviced,

    // Expiry pulses and held levels
    output logic                   t1_timeout_p,
    output logic                   t2_timeout_p,
    output logic                   t1_timeout,
    output logic                   t2_timeout,
    output logic                   fatal_timeout
);

    logic [`MCI_DATA_W-1:0] t1_cnt;
    logic [`MCI_DATA_W-1:0] t2_cnt;
    logic                   t1_hit;
    logic                   t2_hit;
    logic                   t2_run;

    assign t1_hit = (t1_cnt == timer1_period);
    assign t2_hit = (t2_cnt == timer2_period);

    // Stage 2 measures how long stage 1 stays unserviced
    assign t2_run = t1_timeout & ~t1_serviced;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            t1_cnt        <= '0;
            t2_cnt        <= '0;
            t1_timeout_p  <= 1'b0;
            t2_timeout_p  <= 1'b0;
            t1_timeout    <= 1'b0;
            t2_timeout    <= 1'b0;
            fatal_timeout <= 1'b0;
        end else begin
            t1_timeout_p <= 1'b0;
            t2_timeout_p <= 1'b0;

            // Service first, a same-cycle expiry below wins
            if (t1_serviced) begin
                t1_timeout <= 1'b0;
            end
            if (t2_serviced) begin
                t2_timeout    <= 1'b0;
                fatal_timeout <= 1'b0;
            end

            if (restart) begin
                t1_cnt <= '0;
                t2_cnt <= '0;
            end else begin
                // Stage 1, free running while enabled
                if (timer1_en) begin
                    if (t1_hit) begin
                        t1_cnt       <= '0;
                        t1_timeout_p <= 1'b1;
                        t1_timeout   <= 1'b1;
                    end else begin
                        t1_cnt <= t1_cnt + 1'b1;
                    end
                end

                // Stage 2, held at 0 once stage 1 is serviced
                if (!t2_run) begin
                    t2_cnt <= '0;
                end else if (t2_hit) begin
                    t2_cnt        <= '0;
                    t2_timeout_p  <= 1'b1;
                    t2_timeout    <= 1'b1;
                    fatal_timeout <= 1'b1;
                end else begin
                    t2_cnt <= t2_cnt + 1'b1;
                end
            end
        end
    end

endmodule
